/* logic/core_pkg.sv */
// core sizes, alpha operate encodings, alu op codes, instruction word views
package core_pkg;

	// ====================
	// sizes
	localparam int XLEN       = 64;
	localparam int NUM_AREG   = 32;
	localparam int AREG_IDX_W = 5;
	localparam int NUM_PREG   = 64;
	localparam int PREG_IDX_W = 6;
	localparam logic [AREG_IDX_W-1:0] ZERO_REG = 5'd31; // r31, pinned to preg 0
	localparam int ROB_DEPTH  = 16;
	localparam int ROB_IDX_W  = 4;
	localparam int IQ_DEPTH   = 8;
	localparam int IQ_IDX_W   = 3;
	localparam int DQ_DEPTH   = 4; // = credits held by the source after reset
	localparam int DQ_IDX_W   = 2;

	// ====================
	// alpha major opcodes and function codes
	localparam logic [5:0] OPC_INTA  = 6'h10; // add, sub, compares
	localparam logic [5:0] OPC_INTL  = 6'h11; // logic
	localparam logic [5:0] OPC_INTS  = 6'h12; // shifts
	localparam logic [6:0] FN_ADDQ   = 7'h20;
	localparam logic [6:0] FN_SUBQ   = 7'h29;
	localparam logic [6:0] FN_CMPEQ  = 7'h2d;
	localparam logic [6:0] FN_CMPULT = 7'h1d;
	localparam logic [6:0] FN_AND    = 7'h00;
	localparam logic [6:0] FN_BIS    = 7'h20;
	localparam logic [6:0] FN_XOR    = 7'h40;
	localparam logic [6:0] FN_SLL    = 7'h39;
	localparam logic [6:0] FN_SRL    = 7'h34;

	// ====================
	// internal alu ops
	localparam int ALU_OP_W = 4;
	localparam logic [ALU_OP_W-1:0] ALU_NOP    = 4'd0; // illegal words, result 0
	localparam logic [ALU_OP_W-1:0] ALU_ADD    = 4'd1;
	localparam logic [ALU_OP_W-1:0] ALU_SUB    = 4'd2;
	localparam logic [ALU_OP_W-1:0] ALU_CMPEQ  = 4'd3;
	localparam logic [ALU_OP_W-1:0] ALU_CMPULT = 4'd4;
	localparam logic [ALU_OP_W-1:0] ALU_AND    = 4'd5;
	localparam logic [ALU_OP_W-1:0] ALU_BIS    = 4'd6;
	localparam logic [ALU_OP_W-1:0] ALU_XOR    = 4'd7;
	localparam logic [ALU_OP_W-1:0] ALU_SLL    = 4'd8;
	localparam logic [ALU_OP_W-1:0] ALU_SRL    = 4'd9;

	// operate word, bit 12 picks which view holds operand b
	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			logic [4:0] ra;
			logic [4:0] rb;
			logic [2:0] sbz;    // unused in register form
			logic       is_lit;
			logic [6:0] func;
			logic [4:0] rc;
		} r;
		struct packed {
			logic [5:0] opcode;
			logic [4:0] ra;
			logic [7:0] lit;    // zero extended by the alu
			logic       is_lit;
			logic [6:0] func;
			logic [4:0] rc;
		} l;
	} inst_u;

endpackage

/* logic/inst_decode.sv */
// credited decode queue and the operate decoder
`timescale 1ns/1ps

module inst_decode import core_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  logic                  inst_valid_i,
	input  inst_u                 inst_i,
	input  logic                  dispatch_en_i,
	output logic                  dec_valid_o,
	output logic [AREG_IDX_W-1:0] dec_ra_o,
	output logic [AREG_IDX_W-1:0] dec_rb_o,
	output logic [AREG_IDX_W-1:0] dec_rc_o,
	output logic [ALU_OP_W-1:0]   dec_alu_op_o,
	output logic                  dec_use_lit_o,
	output logic [7:0]            dec_lit_o,
	output logic                  dec_illegal_o,
	output logic                  credit_o
);

	inst_u               dq_mem [DQ_DEPTH];
	logic [DQ_IDX_W-1:0] wr_ptr;
	logic [DQ_IDX_W-1:0] rd_ptr;
	logic [DQ_IDX_W:0]   count;
	inst_u               head;
	logic [ALU_OP_W-1:0] op;

	// ====================
	// queue, the source never sends without a credit
	always_ff @(posedge clk) begin
		if (inst_valid_i) begin
			dq_mem[wr_ptr] <= inst_i;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (inst_valid_i) wr_ptr <= wr_ptr + 1'b1;
			if (dispatch_en_i) rd_ptr <= rd_ptr + 1'b1;
			count <= count + {{DQ_IDX_W{1'b0}}, inst_valid_i}
				- {{DQ_IDX_W{1'b0}}, dispatch_en_i};
		end
	end

	assign head        = dq_mem[rd_ptr];
	assign dec_valid_o = (count != '0);
	assign credit_o    = dispatch_en_i; // one credit back per pop

	// ====================
	// decode head word
	always_comb begin
		op = ALU_NOP;
		case (head.r.opcode)
			OPC_INTA: case (head.r.func)
				FN_ADDQ:   op = ALU_ADD;
				FN_SUBQ:   op = ALU_SUB;
				FN_CMPEQ:  op = ALU_CMPEQ;
				FN_CMPULT: op = ALU_CMPULT;
				default:   op = ALU_NOP;
			endcase
			OPC_INTL: case (head.r.func)
				FN_AND:  op = ALU_AND;
				FN_BIS:  op = ALU_BIS;
				FN_XOR:  op = ALU_XOR;
				default: op = ALU_NOP;
			endcase
			OPC_INTS: case (head.r.func)
				FN_SLL:  op = ALU_SLL;
				FN_SRL:  op = ALU_SRL;
				default: op = ALU_NOP;
			endcase
			default: op = ALU_NOP; // unknown opcode
		endcase
	end

	assign dec_illegal_o = (op == ALU_NOP);
	assign dec_alu_op_o  = op;
	assign dec_use_lit_o = head.r.is_lit;
	assign dec_lit_o     = head.l.lit;
	// illegal words read and write r31 only, so they issue at once and touch nothing
	assign dec_ra_o = dec_illegal_o ? ZERO_REG : head.r.ra;
	assign dec_rb_o = (dec_illegal_o || head.r.is_lit) ? ZERO_REG : head.r.rb;
	assign dec_rc_o = dec_illegal_o ? ZERO_REG : head.r.rc;

endmodule

/* logic/rename_unit.sv */
// map table, circular free list and physical ready bits
`timescale 1ns/1ps

module rename_unit import core_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  logic                  dispatch_en_i,
	input  logic [AREG_IDX_W-1:0] ra_i,
	input  logic [AREG_IDX_W-1:0] rb_i,
	input  logic [AREG_IDX_W-1:0] rc_i,
	input  logic                  cdb_valid_i,
	input  logic [PREG_IDX_W-1:0] cdb_tag_i,
	input  logic                  free_valid_i,
	input  logic [PREG_IDX_W-1:0] free_tag_i,
	output logic [PREG_IDX_W-1:0] opa_tag_o,
	output logic [PREG_IDX_W-1:0] opb_tag_o,
	output logic                  opa_rdy_o,
	output logic                  opb_rdy_o,
	output logic [PREG_IDX_W-1:0] new_tag_o,
	output logic [PREG_IDX_W-1:0] old_tag_o
);

	logic [PREG_IDX_W-1:0] map_tbl   [NUM_AREG];
	logic [PREG_IDX_W-1:0] free_list [NUM_PREG-NUM_AREG];
	logic [AREG_IDX_W-1:0] fl_head; // 32 free slots, same width as areg index
	logic [AREG_IDX_W-1:0] fl_tail;
	logic [NUM_PREG-1:0]   preg_rdy;
	logic                  alloc;

	assign alloc = (rc_i != ZERO_REG); // r31 never takes a tag

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < NUM_AREG; i++) begin
				map_tbl[i] <= (i == ZERO_REG) ? '0 : PREG_IDX_W'(i + 1);
			end
			for (int i = 0; i < NUM_PREG - NUM_AREG; i++) begin
				free_list[i] <= PREG_IDX_W'(NUM_AREG + i); // tags 32..63
			end
			fl_head  <= '0;
			fl_tail  <= '0; // list starts full, head == tail
			preg_rdy <= '1;
		end else begin
			if (dispatch_en_i && alloc) begin
				map_tbl[rc_i] <= free_list[fl_head];
				fl_head       <= fl_head + 1'b1;
			end
			// a freed tag is never the one popped this cycle
			if (free_valid_i) begin
				free_list[fl_tail] <= free_tag_i;
				fl_tail            <= fl_tail + 1'b1;
			end
			if (cdb_valid_i) preg_rdy[cdb_tag_i] <= 1'b1;
			if (dispatch_en_i && alloc) preg_rdy[new_tag_o] <= 1'b0;
		end
	end

	// ====================
	// lookup in the dispatch cycle
	assign opa_tag_o = map_tbl[ra_i];
	assign opb_tag_o = map_tbl[rb_i];
	assign opa_rdy_o = preg_rdy[opa_tag_o] | (cdb_valid_i && cdb_tag_i == opa_tag_o);
	assign opb_rdy_o = preg_rdy[opb_tag_o] | (cdb_valid_i && cdb_tag_i == opb_tag_o);
	assign new_tag_o = alloc ? free_list[fl_head] : '0;
	assign old_tag_o = alloc ? map_tbl[rc_i] : '0; // old mapping, freed at retire

endmodule

/* logic/issue_queue.sv */
// reservation entries, cdb wakeup and lowest-index ready select
`timescale 1ns/1ps

module issue_queue import core_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  logic                  dispatch_en_i,
	input  logic [PREG_IDX_W-1:0] opa_tag_i,
	input  logic [PREG_IDX_W-1:0] opb_tag_i,
	input  logic                  opa_rdy_i,
	input  logic                  opb_rdy_i,
	input  logic [PREG_IDX_W-1:0] dest_tag_i,
	input  logic [ROB_IDX_W-1:0]  rob_idx_i,
	input  logic [ALU_OP_W-1:0]   alu_op_i,
	input  logic                  use_lit_i,
	input  logic [7:0]            lit_i,
	input  logic                  cdb_valid_i,
	input  logic [PREG_IDX_W-1:0] cdb_tag_i,
	output logic                  full_o,
	output logic                  iss_valid_o,
	output logic [PREG_IDX_W-1:0] iss_opa_tag_o,
	output logic [PREG_IDX_W-1:0] iss_opb_tag_o,
	output logic [PREG_IDX_W-1:0] iss_dest_tag_o,
	output logic [ROB_IDX_W-1:0]  iss_rob_idx_o,
	output logic [ALU_OP_W-1:0]   iss_alu_op_o,
	output logic                  iss_use_lit_o,
	output logic [7:0]            iss_lit_o
);

	logic [IQ_DEPTH-1:0]   ent_vld;
	logic [IQ_DEPTH-1:0]   ent_rdy_a;
	logic [IQ_DEPTH-1:0]   ent_rdy_b;
	logic [IQ_DEPTH-1:0]   ent_use_lit;
	logic [PREG_IDX_W-1:0] ent_opa  [IQ_DEPTH];
	logic [PREG_IDX_W-1:0] ent_opb  [IQ_DEPTH];
	logic [PREG_IDX_W-1:0] ent_dest [IQ_DEPTH];
	logic [ROB_IDX_W-1:0]  ent_rob  [IQ_DEPTH];
	logic [ALU_OP_W-1:0]   ent_op   [IQ_DEPTH];
	logic [7:0]            ent_lit  [IQ_DEPTH];
	logic [IQ_IDX_W-1:0]   free_idx;
	logic [IQ_IDX_W-1:0]   iss_idx;
	logic                  iss_hit;

	// ====================
	// select, scanned from the top so the lowest index wins
	always_comb begin
		free_idx = '0;
		iss_idx  = '0;
		iss_hit  = 1'b0;
		for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
			if (!ent_vld[i]) free_idx = IQ_IDX_W'(i);
			// literal form waits on ra only
			if (ent_vld[i] && ent_rdy_a[i] && (ent_rdy_b[i] || ent_use_lit[i])) begin
				iss_idx = IQ_IDX_W'(i);
				iss_hit = 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ent_vld   <= '0;
			ent_rdy_a <= '0;
			ent_rdy_b <= '0;
		end else begin
			for (int i = 0; i < IQ_DEPTH; i++) begin // wakeup at the edge
				if (cdb_valid_i && ent_opa[i] == cdb_tag_i) ent_rdy_a[i] <= 1'b1;
				if (cdb_valid_i && ent_opb[i] == cdb_tag_i) ent_rdy_b[i] <= 1'b1;
			end
			if (iss_hit) ent_vld[iss_idx] <= 1'b0;
			if (dispatch_en_i) begin // free slot, never the issuing one
				ent_vld[free_idx]   <= 1'b1;
				ent_rdy_a[free_idx] <= opa_rdy_i; // already cdb-forwarded
				ent_rdy_b[free_idx] <= opb_rdy_i;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (dispatch_en_i) begin
			ent_opa[free_idx]     <= opa_tag_i;
			ent_opb[free_idx]     <= opb_tag_i;
			ent_dest[free_idx]    <= dest_tag_i;
			ent_rob[free_idx]     <= rob_idx_i;
			ent_op[free_idx]      <= alu_op_i;
			ent_use_lit[free_idx] <= use_lit_i;
			ent_lit[free_idx]     <= lit_i;
		end
	end

	assign full_o         = &ent_vld;
	assign iss_valid_o    = iss_hit;
	assign iss_opa_tag_o  = ent_opa[iss_idx];
	assign iss_opb_tag_o  = ent_opb[iss_idx];
	assign iss_dest_tag_o = ent_dest[iss_idx];
	assign iss_rob_idx_o  = ent_rob[iss_idx];
	assign iss_alu_op_o   = ent_op[iss_idx];
	assign iss_use_lit_o  = ent_use_lit[iss_idx];
	assign iss_lit_o      = ent_lit[iss_idx];

endmodule

/* logic/alu_execute.sv */
// operand b select and the single registered alu stage driving the cdb
`timescale 1ns/1ps

module alu_execute import core_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  logic                  iss_valid_i,
	input  logic [XLEN-1:0]       opa_value_i,
	input  logic [XLEN-1:0]       opb_value_i,
	input  logic                  use_lit_i,
	input  logic [7:0]            lit_i,
	input  logic [ALU_OP_W-1:0]   alu_op_i,
	input  logic [PREG_IDX_W-1:0] dest_tag_i,
	input  logic [ROB_IDX_W-1:0]  rob_idx_i,
	output logic                  cdb_valid_o,
	output logic [PREG_IDX_W-1:0] cdb_tag_o,
	output logic [XLEN-1:0]       cdb_value_o,
	output logic [ROB_IDX_W-1:0]  cdb_rob_idx_o
);

	logic [XLEN-1:0] opb;
	logic [XLEN-1:0] result;

	assign opb = use_lit_i ? {{(XLEN-8){1'b0}}, lit_i} : opb_value_i;

	always_comb begin
		case (alu_op_i)
			ALU_ADD:    result = opa_value_i + opb;
			ALU_SUB:    result = opa_value_i - opb;
			ALU_CMPEQ:  result = {{(XLEN-1){1'b0}}, opa_value_i == opb};
			ALU_CMPULT: result = {{(XLEN-1){1'b0}}, opa_value_i < opb}; // unsigned
			ALU_AND:    result = opa_value_i & opb;
			ALU_BIS:    result = opa_value_i | opb;
			ALU_XOR:    result = opa_value_i ^ opb;
			ALU_SLL:    result = opa_value_i << opb[5:0];
			ALU_SRL:    result = opa_value_i >> opb[5:0];
			default:    result = '0; // nop, still completes
		endcase
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) cdb_valid_o <= 1'b0;
		else          cdb_valid_o <= iss_valid_i;
	end

	always_ff @(posedge clk) begin
		if (iss_valid_i) begin
			cdb_tag_o     <= dest_tag_i;
			cdb_value_o   <= result;
			cdb_rob_idx_o <= rob_idx_i;
		end
	end

endmodule

/* logic/preg_file.sv */
// physical register file, one write port and three write-through reads
`timescale 1ns/1ps

module preg_file import core_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  logic                  wr_en_i,
	input  logic [PREG_IDX_W-1:0] wr_tag_i,
	input  logic [XLEN-1:0]       wr_value_i,
	input  logic [PREG_IDX_W-1:0] rda_tag_i,
	input  logic [PREG_IDX_W-1:0] rdb_tag_i,
	input  logic [PREG_IDX_W-1:0] rdc_tag_i,
	output logic [XLEN-1:0]       rda_value_o,
	output logic [XLEN-1:0]       rdb_value_o,
	output logic [XLEN-1:0]       rdc_value_o
);

	logic [XLEN-1:0] regs [NUM_PREG];
	logic            wr_ok;

	assign wr_ok = wr_en_i && (wr_tag_i != '0); // preg 0 stays zero

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < NUM_PREG; i++) regs[i] <= '0;
		end else if (wr_ok) begin
			regs[wr_tag_i] <= wr_value_i;
		end
	end

	assign rda_value_o = (wr_ok && wr_tag_i == rda_tag_i) ? wr_value_i : regs[rda_tag_i];
	assign rdb_value_o = (wr_ok && wr_tag_i == rdb_tag_i) ? wr_value_i : regs[rdb_tag_i];
	assign rdc_value_o = (wr_ok && wr_tag_i == rdc_tag_i) ? wr_value_i : regs[rdc_tag_i];

endmodule

/* logic/reorder_buffer.sv */
// reorder buffer, completion marks, in-order retire and old tag release
`timescale 1ns/1ps

module reorder_buffer import core_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  logic                  dispatch_en_i,
	input  logic [AREG_IDX_W-1:0] areg_i,
	input  logic [PREG_IDX_W-1:0] new_tag_i,
	input  logic [PREG_IDX_W-1:0] old_tag_i,
	input  logic                  illegal_i,
	input  logic                  cdb_valid_i,
	input  logic [ROB_IDX_W-1:0]  cdb_rob_idx_i,
	output logic                  full_o,
	output logic [ROB_IDX_W-1:0]  tail_idx_o,
	output logic                  retire_valid_o,
	output logic [AREG_IDX_W-1:0] retire_areg_o,
	output logic [PREG_IDX_W-1:0] retire_tag_o,
	output logic                  retire_illegal_o,
	output logic                  free_valid_o,
	output logic [PREG_IDX_W-1:0] free_tag_o
);

	logic [AREG_IDX_W-1:0] rob_areg [ROB_DEPTH];
	logic [PREG_IDX_W-1:0] rob_new  [ROB_DEPTH];
	logic [PREG_IDX_W-1:0] rob_old  [ROB_DEPTH];
	logic [ROB_DEPTH-1:0]  rob_ill;
	logic [ROB_DEPTH-1:0]  rob_done;
	logic [ROB_IDX_W-1:0]  head;
	logic [ROB_IDX_W-1:0]  tail;
	logic [ROB_IDX_W:0]    count;
	logic                  retire;

	// ====================
	// pointers and done bits
	assign retire = (count != '0) && rob_done[head]; // one per cycle

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			head     <= '0;
			tail     <= '0;
			count    <= '0;
			rob_done <= '0;
		end else begin
			if (cdb_valid_i) rob_done[cdb_rob_idx_i] <= 1'b1;
			if (dispatch_en_i) begin
				rob_done[tail] <= 1'b0;
				tail           <= tail + 1'b1;
			end
			if (retire) head <= head + 1'b1;
			count <= count + {{ROB_IDX_W{1'b0}}, dispatch_en_i}
				- {{ROB_IDX_W{1'b0}}, retire};
		end
	end

	always_ff @(posedge clk) begin
		if (dispatch_en_i) begin
			rob_areg[tail] <= areg_i;
			rob_new[tail]  <= new_tag_i;
			rob_old[tail]  <= old_tag_i;
			rob_ill[tail]  <= illegal_i;
		end
	end

	// ====================
	// retire side
	assign full_o           = (count == ROB_DEPTH);
	assign tail_idx_o       = tail;
	assign retire_valid_o   = retire;
	assign retire_areg_o    = rob_areg[head];
	assign retire_tag_o     = rob_new[head]; // value read from the third prf port
	assign retire_illegal_o = rob_ill[head];
	assign free_valid_o     = retire && (rob_old[head] != '0); // tag 0 is never freed
	assign free_tag_o       = rob_old[head];

endmodule

/* logic/ooo_core.sv */
// core top, decode, rename, issue, execute and retire wiring
`timescale 1ns/1ps

module ooo_core (
	input  logic        clk,
	input  logic        rst_n_i,
	input  logic        inst_valid_i,
	input  logic [31:0] inst_i,
	output logic        credit_o,
	output logic        retire_valid_o,
	output logic [4:0]  retire_areg_o,
	output logic [63:0] retire_value_o,
	output logic        retire_illegal_o
);

	// decode and rename
	logic        dec_valid;
	logic        dec_use_lit;
	logic        dec_illegal;
	logic        dispatch_en;
	logic [4:0]  dec_ra;
	logic [4:0]  dec_rb;
	logic [4:0]  dec_rc;
	logic [3:0]  dec_alu_op;
	logic [7:0]  dec_lit;
	logic [5:0]  opa_tag;
	logic [5:0]  opb_tag;
	logic [5:0]  new_tag;
	logic [5:0]  old_tag;
	logic        opa_rdy;
	logic        opb_rdy;
	// issue and execute
	logic        iq_full;
	logic        iss_valid;
	logic        iss_use_lit;
	logic [5:0]  iss_opa_tag;
	logic [5:0]  iss_opb_tag;
	logic [5:0]  iss_dest_tag;
	logic [3:0]  iss_rob_idx;
	logic [3:0]  iss_alu_op;
	logic [7:0]  iss_lit;
	logic [63:0] opa_value;
	logic [63:0] opb_value;
	logic        cdb_valid;
	logic [5:0]  cdb_tag;
	logic [63:0] cdb_value;
	logic [3:0]  cdb_rob_idx;
	// retire
	logic        rob_full;
	logic [3:0]  rob_tail;
	logic [5:0]  retire_tag;
	logic        free_valid;
	logic [5:0]  free_tag;

	assign dispatch_en = dec_valid && !iq_full && !rob_full;

	// ====================
	// decode
	inst_decode u_decode (
		.clk(clk), .rst_n_i(rst_n_i),
		.inst_valid_i(inst_valid_i), .inst_i(inst_i), .dispatch_en_i(dispatch_en),
		.dec_valid_o(dec_valid), .dec_ra_o(dec_ra), .dec_rb_o(dec_rb), .dec_rc_o(dec_rc),
		.dec_alu_op_o(dec_alu_op), .dec_use_lit_o(dec_use_lit), .dec_lit_o(dec_lit),
		.dec_illegal_o(dec_illegal), .credit_o(credit_o)
	);

	rename_unit u_rename (
		.clk(clk), .rst_n_i(rst_n_i), .dispatch_en_i(dispatch_en),
		.ra_i(dec_ra), .rb_i(dec_rb), .rc_i(dec_rc),
		.cdb_valid_i(cdb_valid), .cdb_tag_i(cdb_tag),
		.free_valid_i(free_valid), .free_tag_i(free_tag),
		.opa_tag_o(opa_tag), .opb_tag_o(opb_tag), .opa_rdy_o(opa_rdy), .opb_rdy_o(opb_rdy),
		.new_tag_o(new_tag), .old_tag_o(old_tag)
	);

	// ====================
	// execute
	issue_queue u_iq (
		.clk(clk), .rst_n_i(rst_n_i), .dispatch_en_i(dispatch_en),
		.opa_tag_i(opa_tag), .opb_tag_i(opb_tag), .opa_rdy_i(opa_rdy), .opb_rdy_i(opb_rdy),
		.dest_tag_i(new_tag), .rob_idx_i(rob_tail), .alu_op_i(dec_alu_op),
		.use_lit_i(dec_use_lit), .lit_i(dec_lit),
		.cdb_valid_i(cdb_valid), .cdb_tag_i(cdb_tag), .full_o(iq_full),
		.iss_valid_o(iss_valid), .iss_opa_tag_o(iss_opa_tag), .iss_opb_tag_o(iss_opb_tag),
		.iss_dest_tag_o(iss_dest_tag), .iss_rob_idx_o(iss_rob_idx),
		.iss_alu_op_o(iss_alu_op), .iss_use_lit_o(iss_use_lit), .iss_lit_o(iss_lit)
	);

	preg_file u_prf (
		.clk(clk), .rst_n_i(rst_n_i),
		.wr_en_i(cdb_valid), .wr_tag_i(cdb_tag), .wr_value_i(cdb_value),
		.rda_tag_i(iss_opa_tag), .rdb_tag_i(iss_opb_tag), .rdc_tag_i(retire_tag),
		.rda_value_o(opa_value), .rdb_value_o(opb_value), .rdc_value_o(retire_value_o)
	);

	alu_execute u_alu (
		.clk(clk), .rst_n_i(rst_n_i), .iss_valid_i(iss_valid),
		.opa_value_i(opa_value), .opb_value_i(opb_value),
		.use_lit_i(iss_use_lit), .lit_i(iss_lit), .alu_op_i(iss_alu_op),
		.dest_tag_i(iss_dest_tag), .rob_idx_i(iss_rob_idx),
		.cdb_valid_o(cdb_valid), .cdb_tag_o(cdb_tag), .cdb_value_o(cdb_value),
		.cdb_rob_idx_o(cdb_rob_idx)
	);

	// ====================
	// result
	reorder_buffer u_rob (
		.clk(clk), .rst_n_i(rst_n_i), .dispatch_en_i(dispatch_en),
		.areg_i(dec_rc), .new_tag_i(new_tag), .old_tag_i(old_tag), .illegal_i(dec_illegal),
		.cdb_valid_i(cdb_valid), .cdb_rob_idx_i(cdb_rob_idx),
		.full_o(rob_full), .tail_idx_o(rob_tail),
		.retire_valid_o(retire_valid_o), .retire_areg_o(retire_areg_o),
		.retire_tag_o(retire_tag), .retire_illegal_o(retire_illegal_o),
		.free_valid_o(free_valid), .free_tag_o(free_tag)
	);

endmodule

/* dv/core_clk_gen.sv */
// testbench clock and reset generator
`timescale 1ns/1ps

module core_clk_gen (
	output logic clk_o,
	output logic rst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #10 clk_o = ~clk_o; // 20 ns period
	end

	initial begin
		rst_n_o = 1'b0;
		repeat (8) @(posedge clk_o); // reset held 8 cycles
		#2;
		rst_n_o = 1'b1;
	end

endmodule

/* dv/core_tb.sv */
// core testbench, credited stimulus, in-order reference model, retire checks, watchdog
`timescale 1ns/1ps

module core_tb import core_pkg::*; ();

	localparam int N_SEED  = 31; // literal loads and the readback sweep
	localparam int N_RAND  = 200;
	localparam int N_CHAIN = 120;
	localparam int N_LIT   = 100;
	localparam int N_ZERO  = 30;
	localparam int N_ILL   = 40;
	localparam int N_BURST = 96; // 4 bursts of 24
	localparam int N_TOTAL = 2 * N_SEED + N_RAND + N_CHAIN + N_LIT + N_ZERO + N_ILL + N_BURST;
	localparam int WATCHDOG_CYCLES = N_TOTAL * 30 + 200;
	localparam int K_BIS = 5;
	// the nine operates at the same index in both tables
	localparam logic [5:0] OP_TAB [9] = '{OPC_INTA, OPC_INTA, OPC_INTA, OPC_INTA,
		OPC_INTL, OPC_INTL, OPC_INTL, OPC_INTS, OPC_INTS};
	localparam logic [6:0] FN_TAB [9] = '{FN_ADDQ, FN_SUBQ, FN_CMPEQ, FN_CMPULT,
		FN_AND, FN_BIS, FN_XOR, FN_SLL, FN_SRL};

	logic                  clk;
	logic                  rst_n;
	logic                  inst_valid;
	inst_u                 inst_word;
	logic                  credit;
	logic                  retire_valid;
	logic [AREG_IDX_W-1:0] retire_areg;
	logic [XLEN-1:0]       retire_value;
	logic                  retire_illegal;

	int seed = 82;
	int credits = DQ_DEPTH; // source side credit counter
	int credits_returned = 0;
	int words_sent = 0;
	int retired = 0;
	int checks = 0;
	int errors = 0;
	int test_err0 = 0;
	int stall_cycles = 0;
	logic [XLEN-1:0]       arch_reg [NUM_AREG]; // model state
	logic [AREG_IDX_W-1:0] exp_areg_q [$];
	logic [XLEN-1:0]       exp_value_q [$];
	logic                  exp_ill_q [$];

	core_clk_gen u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

	ooo_core u_dut (
		.clk(clk), .rst_n_i(rst_n), .inst_valid_i(inst_valid), .inst_i(inst_word),
		.credit_o(credit), .retire_valid_o(retire_valid), .retire_areg_o(retire_areg),
		.retire_value_o(retire_value), .retire_illegal_o(retire_illegal)
	);

	// ====================
	// checks
	task automatic compare_areg(input string sig, input logic [AREG_IDX_W-1:0] exp_v,
		input logic [AREG_IDX_W-1:0] act);
		checks++;
		if (act !== exp_v) begin
			errors++;
			$display("FAIL t=%0t %s expected %0d got %0d", $time, sig, exp_v, act);
		end
	endtask

	task automatic compare_value(input string sig, input logic [XLEN-1:0] exp_v,
		input logic [XLEN-1:0] act);
		checks++;
		if (act !== exp_v) begin
			errors++;
			$display("FAIL t=%0t %s expected %h got %h", $time, sig, exp_v, act);
		end
	endtask

	task automatic compare_flag(input string sig, input logic exp_v, input logic act);
		checks++;
		if (act !== exp_v) begin
			errors++;
			$display("FAIL t=%0t %s expected %b got %b", $time, sig, exp_v, act);
		end
	endtask

	task automatic report_error(input string msg);
		errors++;
		$display("ERROR t=%0t %s", $time, msg);
	endtask

	task automatic end_test(input string name);
		$display("test %-34s %s, %0d errors", name,
			(errors == test_err0) ? "passed" : "failed", errors - test_err0);
		test_err0 = errors;
	endtask

	// ====================
	// reference model
	function automatic int rand_below(input int n);
		return {$random(seed)} % n;
	endfunction

	function automatic int op_index(input inst_u w); // -1 for an illegal word
		for (int k = 0; k < 9; k++) begin
			if (w.r.opcode == OP_TAB[k] && w.r.func == FN_TAB[k]) return k;
		end
		return -1;
	endfunction

	function automatic inst_u make_op(input int k, input logic lit_form, input int ra,
		input int b, input int rc);
		inst_u w;
		w = '0;
		w.r.opcode = OP_TAB[k];
		w.r.func   = FN_TAB[k];
		w.r.ra     = 5'(ra);
		w.r.rc     = 5'(rc);
		w.r.is_lit = lit_form;
		if (lit_form) w.l.lit = 8'(b);
		else          w.r.rb  = 5'(b);
		return w;
	endfunction

	task automatic model_exec(input inst_u w);
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] res;
		int              k;
		k = op_index(w);
		a = (w.r.ra == ZERO_REG) ? '0 : arch_reg[w.r.ra]; // r31 reads zero
		b = (w.r.rb == ZERO_REG) ? '0 : arch_reg[w.r.rb];
		if (w.r.is_lit) b = {{(XLEN-8){1'b0}}, w.l.lit};
		case (k)
			0:       res = a + b;
			1:       res = a - b;
			2:       res = {{(XLEN-1){1'b0}}, a == b};
			3:       res = {{(XLEN-1){1'b0}}, a < b};
			4:       res = a & b;
			5:       res = a | b;
			6:       res = a ^ b;
			7:       res = a << b[5:0];
			8:       res = a >> b[5:0];
			default: res = '0;
		endcase
		if (k < 0) begin // no write and retires as r31
			exp_areg_q.push_back(ZERO_REG);
			exp_value_q.push_back('0);
			exp_ill_q.push_back(1'b1);
		end else begin
			exp_areg_q.push_back(w.r.rc);
			exp_value_q.push_back((w.r.rc == ZERO_REG) ? '0 : res);
			exp_ill_q.push_back(1'b0);
			if (w.r.rc != ZERO_REG) arch_reg[w.r.rc] = res;
		end
	endtask

	// ====================
	// stimulus entered 2 ns after a rising edge
	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic send_word(input inst_u w);
		while (credits == 0) begin // wait for a credit
			stall_cycles++;
			idle(1);
		end
		inst_valid = 1'b1;
		inst_word  = w;
		credits--;
		words_sent++;
		model_exec(w);
		idle(1);
		inst_valid = 1'b0;
	endtask

	task automatic send_illegal();
		inst_u w;
		w = $random(seed);
		if (rand_below(2) == 0) w.r.opcode = OP_TAB[rand_below(9)]; // bad func only
		while (op_index(w) >= 0) w.r.func = w.r.func + 7'd1;
		send_word(w);
	endtask

	task automatic drain();
		while (exp_areg_q.size() != 0) idle(1);
		idle(2);
	endtask

	// ====================
	// monitors sampled mid-cycle
	always @(negedge clk) begin
		if (rst_n) begin
			if (credit) begin
				credits++; // usable from the next cycle
				credits_returned++;
			end
			if (credits > DQ_DEPTH) report_error("credit count rose above the queue depth");
		end
	end

	always @(negedge clk) begin
		if (rst_n && retire_valid) begin
			if (exp_areg_q.size() == 0) begin
				report_error("retire seen with no instruction outstanding");
			end else begin
				compare_areg("retire_areg_o", exp_areg_q.pop_front(), retire_areg);
				compare_value("retire_value_o", exp_value_q.pop_front(), retire_value);
				compare_flag("retire_illegal_o", exp_ill_q.pop_front(), retire_illegal);
				retired++;
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired, retirement stalled with %0d instructions outstanding",
			exp_areg_q.size());
		$display("CHECKS FAILED");
		$finish;
	end

	// ====================
	// test sequence
	initial begin
		inst_valid = 1'b0;
		inst_word  = '0;
		for (int r = 0; r < NUM_AREG; r++) arch_reg[r] = '0;
		wait (rst_n === 1'b1);
		idle(1);

		repeat (20) begin // nothing sent and nothing comes back
			@(negedge clk);
			compare_flag("credit_o", 1'b0, credit);
			compare_flag("retire_valid_o", 1'b0, retire_valid);
		end
		idle(1);
		end_test("1 quiet after reset");

		for (int r = 0; r < N_SEED; r++) begin // spread some bits first
			send_word(make_op(K_BIS, 1'b1, ZERO_REG, rand_below(256), r));
		end
		for (int i = 0; i < N_RAND; i++) begin
			send_word(make_op((i < 9) ? i : rand_below(9), 1'b0,
				rand_below(32), rand_below(32), rand_below(32)));
		end
		drain();
		end_test("2 random register form");

		for (int i = 0; i < N_CHAIN; i++) begin // r1..r4 only
			send_word(make_op(rand_below(9), 1'b0,
				1 + rand_below(4), 1 + rand_below(4), 1 + rand_below(4)));
			idle(rand_below(4));
		end
		drain();
		end_test("3 dependent chains");

		for (int i = 0; i < N_LIT; i++) begin
			if (rand_below(2) == 0)
				send_word(make_op(rand_below(9), 1'b1, 5 + rand_below(4), rand_below(256),
					5 + rand_below(4)));
			else
				send_word(make_op(rand_below(9), 1'b0, 5 + rand_below(4), 5 + rand_below(4),
					5 + rand_below(4)));
		end
		drain();
		end_test("4 literal and mixed forms");

		for (int i = 0; i < N_ZERO; i++) begin // writes to r31 then reads of r31
			if (i % 2 == 0)
				send_word(make_op(rand_below(9), 1'b0, rand_below(32), rand_below(32), ZERO_REG));
			else
				send_word(make_op(rand_below(9), 1'b0, ZERO_REG, rand_below(32), rand_below(31)));
		end
		for (int i = 0; i < N_ILL; i++) send_illegal();
		for (int r = 0; r < N_SEED; r++) begin // readback of the untouched state
			send_word(make_op(K_BIS, 1'b1, r, 0, r));
		end
		drain();
		end_test("5 r31 and illegal words");

		for (int b = 0; b < N_BURST / 24; b++) begin // serial chain on r9 backs up the iq
			for (int j = 0; j < 24; j++) begin
				send_word(make_op(rand_below(9), 1'b0, 9, 9 + rand_below(2), 9));
			end
			idle(rand_below(6));
		end
		drain();
		if (credits_returned != words_sent)
			report_error($sformatf("%0d credits returned for %0d words sent",
				credits_returned, words_sent));
		if (credits != DQ_DEPTH)
			report_error($sformatf("credit count ended at %0d after drain", credits));
		end_test($sformatf("6 credit bursts, %0d stall cycles", stall_cycles));

		$display("summary %0d checks, %0d errors, %0d sent, %0d retired, %0d credits back",
			checks, errors, words_sent, retired, credits_returned);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

/* files.f */
logic/core_pkg.sv
logic/inst_decode.sv
logic/rename_unit.sv
logic/issue_queue.sv
logic/alu_execute.sv
logic/preg_file.sv
logic/reorder_buffer.sv
logic/ooo_core.sv
dv/core_clk_gen.sv
dv/core_tb.sv

/* Bender.yml */
package:
  name: ooo_core

sources:
  # rtl, package first
  - files:
      - logic/core_pkg.sv
      - logic/inst_decode.sv
      - logic/rename_unit.sv
      - logic/issue_queue.sv
      - logic/alu_execute.sv
      - logic/preg_file.sv
      - logic/reorder_buffer.sv
      - logic/ooo_core.sv
  # testbench
  - target: test
    files:
      - dv/core_clk_gen.sv
      - dv/core_tb.sv
